/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mem_subsystem
RTL_TOP    := mem_subsystem
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/dtim_bank.sv */
module dtim_bank import mem_pkg::*; #(
  parameter int LANE = 0
) (
  input logic  clock,
  dtim_if.bank dtim
);

  logic [7:0] ram [DEPTH];
  logic [7:0] rdata_q;
  logic [7:0] wbyte;
  logic       we;

  assign wbyte = dtim.wdata[LANE*8 +: 8];
  assign we    = dtim.en & dtim.wstrb[LANE];

  always_ff @(posedge clock) begin
    if (we) begin
      ram[dtim.index] <= wbyte;
    end
  end

  // Read before write on the same index
  always_ff @(posedge clock) begin
    if (dtim.en) begin
      rdata_q <= ram[dtim.index];
    end
  end

  assign dtim.rdata[LANE*8 +: 8] = rdata_q;

  a_index_known: assert property (@(posedge clock)
    dtim.en |-> !$isunknown(dtim.index));

endmodule

/* source/dtim_if.sv */
interface dtim_if import mem_pkg::*; ();

  // Request side
  logic               en;
  logic [INDEX_W-1:0] index;
  logic [LANES-1:0]   wstrb;
  logic [XLEN-1:0]    wdata;  // One byte per lane

  // Each bank drives its own read byte
  logic [XLEN-1:0]    rdata;

  modport issuer (
    output en,
    output index,
    output wstrb,
    output wdata
  );

  modport bank (
    input  en,
    input  index,
    input  wstrb,
    input  wdata,
    output rdata
  );

  modport drain (
    input rdata
  );

endinterface

/* source/load_align.sv */
module load_align import mem_pkg::*; (
  dtim_if.drain           dtim,
  input  lsu_op_t         op,
  input  logic [1:0]      offset,
  output logic [XLEN-1:0] ldata
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // ##############################
  // Lane select
  // ##############################

  always_comb begin
    case (offset)
      2'd0:    byte_sel = dtim.rdata[7:0];
      2'd1:    byte_sel = dtim.rdata[15:8];
      2'd2:    byte_sel = dtim.rdata[23:16];
      default: byte_sel = dtim.rdata[31:24];
    endcase
    half_sel = offset[1] ? dtim.rdata[31:16] : dtim.rdata[15:0];
  end

  // ##############################
  // Extension
  // ##############################

  always_comb begin
    case (op)
      LSU_LB:  ldata = {{(XLEN-8){byte_sel[7]}}, byte_sel};
      LSU_LBU: ldata = {{(XLEN-8){1'b0}}, byte_sel};
      LSU_LH:  ldata = {{(XLEN-16){half_sel[15]}}, half_sel};
      LSU_LHU: ldata = {{(XLEN-16){1'b0}}, half_sel};
      LSU_LW:  ldata = dtim.rdata;
      default: ldata = '0;  // Stores and idle
    endcase
  end

  // Stage filters faulting halves before they get here
  always_comb begin
    if (op inside {LSU_LH, LSU_LHU}) begin
      a_half_even: assert (offset[0] == 1'b0)
        else $error("half load with odd offset %0d", offset);
    end
  end

endmodule

/* source/mem_pkg.sv */
package mem_pkg;

  // ##############################
  // Widths and sizes
  // ##############################

  localparam int XLEN    = 32;
  localparam int LANES   = 4;   // Byte banks
  localparam int DEPTH   = 256; // Words per bank
  localparam int INDEX_W = 8;   // log2(DEPTH)
  localparam int REG_W   = 5;

  // ##############################
  // Opcodes and causes
  // ##############################

  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LH   = 4'd2,
    LSU_LW   = 4'd3,
    LSU_LBU  = 4'd4,
    LSU_LHU  = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_t;

  typedef enum logic [1:0] {
    CAUSE_NONE             = 2'd0,
    CAUSE_LOAD_MISALIGNED  = 2'd1,
    CAUSE_STORE_MISALIGNED = 2'd2
  } mem_cause_t;

  // ##############################
  // Stage register
  // ##############################

  typedef struct packed {
    logic             valid;
    lsu_op_t          op;
    logic [1:0]       offset;  // Byte offset within the word
    logic [REG_W-1:0] rd;
    logic             wren;
    logic             exc;
    mem_cause_t       cause;
    logic [XLEN-1:0]  addr;    // Faulting address
  } mem_reg_t;

  localparam mem_reg_t init_mem_reg = '{
    valid  : 1'b0,
    op     : LSU_NONE,
    offset : 2'b00,
    rd     : '0,
    wren   : 1'b0,
    exc    : 1'b0,
    cause  : CAUSE_NONE,
    addr   : '0
  };

endpackage

/* source/mem_subsystem.sv */
module mem_subsystem import mem_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             req_valid,
  input  lsu_op_t          req_op,
  input  logic [XLEN-1:0]  req_addr,
  input  logic [XLEN-1:0]  req_sdata,
  input  logic [REG_W-1:0] req_rd,
  input  logic             clear,
  input  logic             hold,
  output logic             wb_wren,
  output logic [REG_W-1:0] wb_rd,
  output logic [XLEN-1:0]  wb_data,
  output logic             exc_valid,
  output mem_cause_t       exc_cause,
  output logic [XLEN-1:0]  exc_addr
);

  logic [XLEN-1:0] ldata;
  lsu_op_t         ld_op;
  logic [1:0]      ld_offset;

  dtim_if dtim ();

  memory_stage i_memory_stage (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_sdata (req_sdata),
    .req_rd    (req_rd),
    .clear     (clear),
    .hold      (hold),
    .dtim      (dtim.issuer),
    .ldata     (ldata),
    .ld_op     (ld_op),
    .ld_offset (ld_offset),
    .wb_wren   (wb_wren),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .exc_valid (exc_valid),
    .exc_cause (exc_cause),
    .exc_addr  (exc_addr)
  );

  // One bank per byte lane
  for (genvar g = 0; g < LANES; g++) begin : g_bank
    dtim_bank #(
      .LANE (g)
    ) i_dtim_bank (
      .clock (clock),
      .dtim  (dtim.bank)
    );
  end

  load_align i_load_align (
    .dtim   (dtim.drain),
    .op     (ld_op),
    .offset (ld_offset),
    .ldata  (ldata)
  );

endmodule

/* source/memory_stage.sv */
module memory_stage import mem_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             req_valid,
  input  lsu_op_t          req_op,
  input  logic [XLEN-1:0]  req_addr,
  input  logic [XLEN-1:0]  req_sdata,
  input  logic [REG_W-1:0] req_rd,
  input  logic             clear,
  input  logic             hold,
  dtim_if.issuer           dtim,
  input  logic [XLEN-1:0]  ldata,
  output lsu_op_t          ld_op,
  output logic [1:0]       ld_offset,
  output logic             wb_wren,
  output logic [REG_W-1:0] wb_rd,
  output logic [XLEN-1:0]  wb_data,
  output logic             exc_valid,
  output mem_cause_t       exc_cause,
  output logic [XLEN-1:0]  exc_addr
);

  mem_reg_t r, rin;

  logic is_load, is_store;
  logic is_half, is_word;
  logic misaligned;
  logic issue;

  function automatic logic [XLEN-1:0] store_data(input logic [XLEN-1:0] sdata,
                                                 input lsu_op_t op);
    logic [XLEN-1:0] data;
    case (op)
      LSU_SB:  data = {4{sdata[7:0]}};
      LSU_SH:  data = {2{sdata[15:0]}};
      default: data = sdata;
    endcase
    return data;
  endfunction

  // ##############################
  // Decode and issue
  // ##############################

  always_comb begin
    is_load  = req_op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
    is_store = req_op inside {LSU_SB, LSU_SH, LSU_SW};
    is_half  = req_op inside {LSU_LH, LSU_LHU, LSU_SH};
    is_word  = req_op inside {LSU_LW, LSU_SW};

    misaligned = (is_half & req_addr[0]) | (is_word & (req_addr[1:0] != 2'b00));

    // Banks see nothing while held, cleared or faulting
    issue = req_valid & ~hold & ~clear & (is_load | is_store) & ~misaligned;

    dtim.en    = issue;
    dtim.index = req_addr[INDEX_W+1:2];
    dtim.wdata = store_data(req_sdata, req_op);

    dtim.wstrb = '0;
    if (issue & is_store) begin
      if (is_word) begin
        dtim.wstrb = '1;
      end else if (is_half) begin
        dtim.wstrb = LANES'(2'b11) << req_addr[1:0];
      end else begin
        dtim.wstrb = LANES'(1'b1) << req_addr[1:0];
      end
    end
  end

  // ##############################
  // Stage register
  // ##############################

  always_comb begin
    rin = r;
    if (hold == 1'b0) begin
      rin.valid  = req_valid & (is_load | is_store);
      rin.op     = req_op;
      rin.offset = req_addr[1:0];
      rin.rd     = req_rd;
      rin.wren   = is_load & ~misaligned & (req_rd != '0); // x0 never written
      rin.exc    = misaligned;
      rin.cause  = !misaligned ? CAUSE_NONE
                 : is_store   ? CAUSE_STORE_MISALIGNED
                 :              CAUSE_LOAD_MISALIGNED;
      rin.addr   = req_addr;
    end
    if (clear == 1'b1) begin
      rin = init_mem_reg;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      r <= init_mem_reg;
    end else begin
      r <= rin;
    end
  end

  // Aligner only sees ops that actually reached memory
  assign ld_op     = (r.valid & ~r.exc) ? r.op : LSU_NONE;
  assign ld_offset = r.offset;

  assign wb_wren   = r.valid & r.wren & ~clear;
  assign wb_rd     = r.rd;
  assign wb_data   = ldata;
  assign exc_valid = r.valid & r.exc & ~clear;
  assign exc_cause = r.cause;
  assign exc_addr  = r.addr;

  a_no_strobe_idle: assert property (@(posedge clock) disable iff (reset == 1'b0)
    !dtim.en |-> (dtim.wstrb == '0));

  a_wb_exc_exclusive: assert property (@(posedge clock) disable iff (reset == 1'b0)
    !(wb_wren & exc_valid));

endmodule

/* src.f */
source/mem_pkg.sv
source/dtim_if.sv
source/dtim_bank.sv
source/load_align.sv
source/memory_stage.sv
source/mem_subsystem.sv
verif/tb_mem_subsystem.sv

/* verif/tb_mem_subsystem.sv */
module tb_mem_subsystem import mem_pkg::*; ();

  typedef struct packed {
    logic             wren;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
    logic             exc;
    mem_cause_t       cause;
    logic [XLEN-1:0]  addr;
  } result_t;

  logic             clock;
  logic             reset;
  logic             req_valid;
  lsu_op_t          req_op;
  logic [XLEN-1:0]  req_addr;
  logic [XLEN-1:0]  req_sdata;
  logic [REG_W-1:0] req_rd;
  logic             clear;
  logic             hold;
  logic             wb_wren;
  logic [REG_W-1:0] wb_rd;
  logic [XLEN-1:0]  wb_data;
  logic             exc_valid;
  mem_cause_t       exc_cause;
  logic [XLEN-1:0]  exc_addr;

  logic [7:0]      shadow [LANES*DEPTH];  // Byte-addressed copy of the DTIM
  result_t         pend_q [$:1];          // Captured with result due next cycle
  result_t         exp_now;               // Record the outputs should show now
  logic            last_hold;
  logic            last_clear;
  logic            prev_hold;
  logic [XLEN-1:0] prev_data;
  logic [8:0]      prev_flags;
  string           test_name;
  int              errors;
  int              test_start;
  int              tests_run;
  int              tests_failed;

  mem_subsystem i_mem_subsystem (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_sdata (req_sdata),
    .req_rd    (req_rd),
    .clear     (clear),
    .hold      (hold),
    .wb_wren   (wb_wren),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .exc_valid (exc_valid),
    .exc_cause (exc_cause),
    .exc_addr  (exc_addr)
  );

  always #5 clock = ~clock;

  // Outputs of the cycle that just ended
  always @(posedge clock) begin
    prev_hold  <= hold;
    prev_data  <= wb_data;
    prev_flags <= {wb_wren, exc_valid, exc_cause, wb_rd};
  end

  // ##############################
  // Reference model
  // ##############################

  function automatic result_t apply_model(input lsu_op_t op, input logic [XLEN-1:0] addr,
                                          input logic [XLEN-1:0] sdata,
                                          input logic [REG_W-1:0] rd);
    result_t         res;
    int              size;
    int              base;
    logic            load;
    logic [XLEN-1:0] word;
    res  = '0;
    word = '0;
    load = op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
    size = op inside {LSU_LB, LSU_LBU, LSU_SB} ? 1 : op inside {LSU_LH, LSU_LHU, LSU_SH} ? 2 : 4;
    base = int'(addr[9:0]);
    if ((addr & (size - 1)) != 0) begin  // Faulting access leaves memory alone
      res.exc   = 1'b1;
      res.cause = load ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
      res.addr  = addr;
    end else if (!load) begin
      for (int i = 0; i < size; i++) begin
        shadow[base + i] = sdata[8*i +: 8];
      end
    end else begin
      for (int i = 0; i < size; i++) begin
        word[8*i +: 8] = shadow[base + i];
      end
      if (op == LSU_LB) word = {{24{word[7]}}, word[7:0]};
      if (op == LSU_LH) word = {{16{word[15]}}, word[15:0]};
      res.wren = (rd != '0);
      res.rd   = rd;
      res.data = word;
    end
    return res;
  endfunction

  function automatic logic [REG_W-1:0] rand_rd();
    return REG_W'($urandom_range(31, 1));
  endfunction

  task automatic report_mismatch(input string what, input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
    errors++;
    $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
  endtask

  // ##############################
  // Checks
  // ##############################

  a_wren: assert property (@(posedge clock) disable iff (reset == 1'b0)
    wb_wren == (exp_now.wren & ~clear))
    else report_mismatch("wb_wren", 32'($sampled(exp_now.wren) & ~$sampled(clear)),
                         32'($sampled(wb_wren)));

  a_exc: assert property (@(posedge clock) disable iff (reset == 1'b0)
    exc_valid == (exp_now.exc & ~clear))
    else report_mismatch("exc_valid", 32'($sampled(exp_now.exc) & ~$sampled(clear)),
                         32'($sampled(exc_valid)));

  a_rd: assert property (@(posedge clock) disable iff (reset == 1'b0)
    (exp_now.wren & ~clear) |-> wb_rd == exp_now.rd)
    else report_mismatch("wb_rd", 32'($sampled(exp_now.rd)), 32'($sampled(wb_rd)));

  a_data: assert property (@(posedge clock) disable iff (reset == 1'b0)
    (exp_now.wren & ~clear) |-> wb_data == exp_now.data)
    else report_mismatch("wb_data", $sampled(exp_now.data), $sampled(wb_data));

  a_cause: assert property (@(posedge clock) disable iff (reset == 1'b0)
    (exp_now.exc & ~clear) |-> exc_cause == exp_now.cause)
    else report_mismatch("exc_cause", 32'($sampled(exp_now.cause)), 32'($sampled(exc_cause)));

  a_addr: assert property (@(posedge clock) disable iff (reset == 1'b0)
    (exp_now.exc & ~clear) |-> exc_addr == exp_now.addr)
    else report_mismatch("exc_addr", $sampled(exp_now.addr), $sampled(exc_addr));

  // Frozen stage repeats its outputs
  a_hold_data: assert property (@(posedge clock) disable iff (reset == 1'b0)
    prev_hold |-> wb_data == prev_data)
    else report_mismatch("held wb_data", $sampled(prev_data), $sampled(wb_data));

  a_hold_flags: assert property (@(posedge clock) disable iff (reset == 1'b0)
    prev_hold |-> {wb_wren, exc_valid, exc_cause, wb_rd} == prev_flags)
    else report_mismatch("held flags", 32'($sampled(prev_flags)),
                         32'($sampled({wb_wren, exc_valid, exc_cause, wb_rd})));

  // ##############################
  // Stimulus
  // ##############################

  task automatic drive_cycle(input logic valid, input lsu_op_t op, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] sdata, input logic [REG_W-1:0] rd,
                             input logic hold_in, input logic clear_in);
    @(negedge clock);
    // Stage register as of the edge just passed
    if (last_clear) begin
      exp_now = '0;
    end else if (!last_hold) begin
      if (pend_q.size() != 0) exp_now = pend_q.pop_front();
      else exp_now = '0;
    end
    req_valid  = valid;
    req_op     = op;
    req_addr   = addr;
    req_sdata  = sdata;
    req_rd     = rd;
    hold       = hold_in;
    clear      = clear_in;
    if (valid & ~hold_in & ~clear_in) pend_q.push_back(apply_model(op, addr, sdata, rd));
    last_hold  = hold_in;
    last_clear = clear_in;
  endtask

  task automatic send(input lsu_op_t op, input logic [XLEN-1:0] addr,
                      input logic [XLEN-1:0] sdata, input logic [REG_W-1:0] rd);
    drive_cycle(1'b1, op, addr, sdata, rd, 1'b0, 1'b0);
  endtask

  task automatic idle();
    drive_cycle(1'b0, LSU_NONE, '0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    do begin
      idle();
      waited++;
    end while ((prev_flags[8:7] != 2'b00 || exp_now.wren || exp_now.exc) && waited < 10);
    if (prev_flags[8:7] != 2'b00) begin
      errors++;
      $display("Outputs did not return to idle within 10 cycles in test %s", test_name);
    end
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    test_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    wait_idle();
    if (errors == test_start) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - test_start);
    end
  endtask

  initial begin
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] base;
    lsu_op_t         op;
    clock = 1'b0;
    reset = 1'b0;
    req_valid = 1'b0;
    req_op = LSU_NONE;
    req_addr = '0;
    req_sdata = '0;
    req_rd = '0;
    clear = 1'b0;
    hold = 1'b0;
    exp_now = '0;
    last_hold = 1'b0;
    last_clear = 1'b0;
    prev_hold = 1'b0;
    prev_data = '0;
    prev_flags = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(44));
    repeat (3) @(negedge clock);
    reset = 1'b1;

    begin_test("reset_idle");
    repeat (4) idle();
    end_test();

    begin_test("preload");
    for (int i = 0; i < DEPTH; i++) send(LSU_SW, XLEN'(i * 4), $urandom, '0);
    end_test();

    begin_test("word_rw");
    for (int n = 0; n < 20; n++) begin
      addr = $urandom & 32'h3FC;
      send(LSU_SW, addr, $urandom, '0);
      send(LSU_LW, addr, '0, rand_rd());
    end
    send(LSU_LW, addr, '0, '0);  // x0 gets no writeback
    end_test();

    begin_test("sub_word");
    for (int n = 0; n < 40; n++) begin
      base = $urandom & 32'h3FC;
      if ($urandom_range(1, 0) == 0) send(LSU_SB, base | ($urandom & 3), $urandom, '0);
      else send(LSU_SH, base | ($urandom & 2), $urandom, '0);
      case ($urandom_range(3, 0))
        0:       op = LSU_LB;
        1:       op = LSU_LBU;
        2:       op = LSU_LH;
        default: op = LSU_LHU;
      endcase
      addr = base | ($urandom & (op inside {LSU_LB, LSU_LBU} ? 3 : 2));
      send(op, addr, '0, rand_rd());
    end
    end_test();

    begin_test("misaligned");
    for (int n = 0; n < 15; n++) begin
      base = $urandom & 32'hFFFF_FFFC;  // Upper bits show up in exc_addr
      case ($urandom_range(4, 0))
        0:       op = LSU_LH;
        1:       op = LSU_LHU;
        2:       op = LSU_SH;
        3:       op = LSU_LW;
        default: op = LSU_SW;
      endcase
      if (op inside {LSU_LW, LSU_SW}) addr = base | $urandom_range(3, 1);
      else addr = base | 1 | ($urandom & 2);
      send(op, addr, $urandom, rand_rd());
      send(LSU_LW, addr & 32'h3FC, '0, rand_rd());
    end
    end_test();

    begin_test("clear");
    for (int n = 0; n < 6; n++) begin
      addr = $urandom & 32'h3FC;
      send(LSU_LW, addr, '0, rand_rd());
      drive_cycle(1'b0, LSU_NONE, '0, '0, '0, 1'b0, 1'b1);
      send(LSU_LH, addr | 1, '0, rand_rd());
      drive_cycle(1'b0, LSU_NONE, '0, '0, '0, 1'b0, 1'b1);
    end
    end_test();

    begin_test("hold");
    for (int n = 0; n < 4; n++) begin
      addr = $urandom & 32'h3FC;
      if (n % 2 == 0) send(LSU_LW, addr, '0, rand_rd());
      else send(LSU_SW, addr | 2, $urandom, '0);
      // Held stores must not reach memory
      repeat (4) drive_cycle(1'b1, LSU_SW, addr, $urandom, '0, 1'b1, 1'b0);
      idle();
      send(LSU_LW, addr, '0, rand_rd());
    end
    end_test();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    for (int i = 0; i < 5000; i++) @(posedge clock);
    $display("Timeout after 5000 cycles in test %s", test_name);
    $display("Simulation failed");
    $finish;
  end

endmodule
